/* axi_mem_consts.svh */
`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// ====================
// memory map
// ====================

// byte address of word 0
`define AXI_MEM_BASE 32'h8000_0000

// depth in 32-bit words
`define AXI_MEM_WORDS 1024

// word index width is log2 of the depth
`define AXI_MEM_IW 10

// ====================
// response codes
// ====================

`define AXI_RESP_OKAY 2'b00

`endif

/* axi_mem_pkg.sv */
`include "axi_mem_consts.svh"

package axi_mem_pkg;

   // ====================
   // channel payloads
   // ====================

   // shared by AR and AW
   typedef struct packed {
      logic [31:0] addr;
      logic [7:0]  len;   // beats minus one
      logic [2:0]  size;
      logic [1:0]  burst;
   } axi_addr_req_t;

   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  strb;
      logic        last;
   } axi_w_beat_t;

   typedef struct packed {
      logic [31:0] data;
      logic [1:0]  resp;
      logic        last;
   } axi_r_beat_t;

   // ====================
   // word store access
   // ====================

   typedef logic [`AXI_MEM_IW-1:0] mem_index_t;

   // one byte-strobed store write
   typedef struct packed {
      mem_index_t  index;
      logic [31:0] data;
      logic [3:0]  strb;
   } mem_wr_t;

   // byte address to word index aliased modulo the depth
   function automatic mem_index_t word_index(input logic [31:0] addr);
      logic [31:0] offset;
      offset = addr - `AXI_MEM_BASE;
      return offset[`AXI_MEM_IW+1:2];
   endfunction

endpackage

/* axi_word_store.sv */
`timescale 1ns/100ps
`include "axi_mem_consts.svh"

module axi_word_store (
   input  logic                    clk,

   // read port
   input  axi_mem_pkg::mem_index_t rd_index,
   output logic [31:0]             rd_data,

   // write port
   input  logic                    wr_en,
   input  axi_mem_pkg::mem_wr_t    wr
);

   // ====================
   // storage
   // ====================

   logic [31:0] mem [`AXI_MEM_WORDS];

   // async read of current contents
   // a same-cycle write shows up only after the edge
   assign rd_data = mem[rd_index];

   // ====================
   // byte lane writes
   // ====================

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (wr.strb[lane]) begin
               mem[wr.index][lane*8 +: 8] <= wr.data[lane*8 +: 8];
            end
         end
      end
   end

endmodule

/* axi_read_engine.sv */
`timescale 1ns/100ps
`include "axi_mem_consts.svh"

module axi_read_engine (
   input  logic                       clk,
   input  logic                       rst,

   // AR channel
   input  axi_mem_pkg::axi_addr_req_t ar,
   input  logic                       arvalid,
   output logic                       arready,

   // R channel
   output axi_mem_pkg::axi_r_beat_t   r,
   output logic                       rvalid,
   input  logic                       rready,

   // store read port
   output axi_mem_pkg::mem_index_t    rd_index,
   input  logic [31:0]                rd_data
);

   typedef enum logic {
      RD_IDLE,
      RD_SEND
   } rd_state_t;

   rd_state_t state;

   // captured request with size and burst kept but not acted on
   axi_mem_pkg::axi_addr_req_t req_q;
   logic [31:0]                beat_addr;
   logic [7:0]                 beat_cnt;

   logic ar_fire;
   logic r_fire;
   logic last_beat;

   assign arready   = (state == RD_IDLE);
   assign rvalid    = (state == RD_SEND);
   assign ar_fire   = arvalid && arready;
   assign r_fire    = rvalid && rready;
   assign last_beat = (beat_cnt == req_q.len);

   // ====================
   // state machine
   // ====================

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= RD_IDLE;
         beat_cnt <= '0;
      end else begin
         case (state)
            RD_IDLE: begin
               if (ar_fire) begin
                  state    <= RD_SEND;
                  beat_cnt <= '0;
               end
            end
            RD_SEND: begin
               // hold the beat until the master takes it
               if (r_fire) begin
                  beat_cnt <= beat_cnt + 8'd1;
                  if (last_beat) begin
                     state <= RD_IDLE;
                  end
               end
            end
            default: state <= RD_IDLE;
         endcase
      end
   end

   // request and beat address
   always_ff @(posedge clk) begin
      if (ar_fire) begin
         req_q     <= ar;
         beat_addr <= ar.addr;
      end else if (r_fire) begin
         beat_addr <= beat_addr + 32'd4;
      end
   end

   // ====================
   // beat output
   // ====================

   assign rd_index = axi_mem_pkg::word_index(beat_addr);

   assign r.data = rd_data;
   assign r.resp = `AXI_RESP_OKAY;
   assign r.last = last_beat;

endmodule

/* axi_write_engine.sv */
`timescale 1ns/100ps
`include "axi_mem_consts.svh"

module axi_write_engine (
   input  logic                       clk,
   input  logic                       rst,

   // AW channel
   input  axi_mem_pkg::axi_addr_req_t aw,
   input  logic                       awvalid,
   output logic                       awready,

   // W channel
   input  axi_mem_pkg::axi_w_beat_t   w,
   input  logic                       wvalid,
   output logic                       wready,

   // B channel
   output logic [1:0]                 bresp,
   output logic                       bvalid,
   input  logic                       bready,

   // store write port
   output logic                       wr_en,
   output axi_mem_pkg::mem_wr_t       wr
);

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_RECV,
      WR_RESP
   } wr_state_t;

   wr_state_t state;

   axi_mem_pkg::axi_addr_req_t req_q;
   logic [31:0]                beat_addr;
   logic [7:0]                 beat_cnt;

   logic aw_fire;
   logic w_fire;
   logic b_fire;

   assign awready = (state == WR_IDLE);
   assign wready  = (state == WR_RECV);
   assign bvalid  = (state == WR_RESP);
   assign bresp   = `AXI_RESP_OKAY;

   assign aw_fire = awvalid && awready;
   assign w_fire  = wvalid && wready;
   assign b_fire  = bvalid && bready;

   // ====================
   // state machine
   // ====================

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= WR_IDLE;
         beat_cnt <= '0;
      end else begin
         case (state)
            WR_IDLE: begin
               if (aw_fire) begin
                  state    <= WR_RECV;
                  beat_cnt <= '0;
               end
            end
            WR_RECV: begin
               // burst ends on the beat count and wlast is ignored
               if (w_fire) begin
                  beat_cnt <= beat_cnt + 8'd1;
                  if (beat_cnt == req_q.len) begin
                     state <= WR_RESP;
                  end
               end
            end
            WR_RESP: begin
               if (b_fire) begin
                  state <= WR_IDLE;
               end
            end
            default: state <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (aw_fire) begin
         req_q     <= aw;
         beat_addr <= aw.addr;
      end else if (w_fire) begin
         beat_addr <= beat_addr + 32'd4;
      end
   end

   // ====================
   // store write
   // ====================

   // lands in the store on the same edge as the W transfer
   assign wr_en    = w_fire;
   assign wr.index = axi_mem_pkg::word_index(beat_addr);
   assign wr.data  = w.data;
   assign wr.strb  = w.strb;

endmodule

/* axi_mem_top.sv */
`timescale 1ns/100ps

module axi_mem_top (
   input  logic                       clk,
   input  logic                       rst,

   // read address and data
   input  axi_mem_pkg::axi_addr_req_t ar,
   input  logic                       arvalid,
   output logic                       arready,
   output axi_mem_pkg::axi_r_beat_t   r,
   output logic                       rvalid,
   input  logic                       rready,

   // write address, data and response
   input  axi_mem_pkg::axi_addr_req_t aw,
   input  logic                       awvalid,
   output logic                       awready,
   input  axi_mem_pkg::axi_w_beat_t   w,
   input  logic                       wvalid,
   output logic                       wready,
   output logic [1:0]                 bresp,
   output logic                       bvalid,
   input  logic                       bready
);

   axi_mem_pkg::mem_index_t rd_index;
   logic [31:0]             rd_data;
   axi_mem_pkg::mem_wr_t    wr;
   logic                    wr_en;

   // ====================
   // engines
   // ====================

   axi_read_engine axi_read_engine_i (
      .clk      (clk),
      .rst      (rst),
      .ar       (ar),
      .arvalid  (arvalid),
      .arready  (arready),
      .r        (r),
      .rvalid   (rvalid),
      .rready   (rready),
      .rd_index (rd_index),
      .rd_data  (rd_data)
   );

   axi_write_engine axi_write_engine_i (
      .clk     (clk),
      .rst     (rst),
      .aw      (aw),
      .awvalid (awvalid),
      .awready (awready),
      .w       (w),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .wr_en   (wr_en),
      .wr      (wr)
   );

   // shared word store
   axi_word_store axi_word_store_i (
      .clk      (clk),
      .rd_index (rd_index),
      .rd_data  (rd_data),
      .wr_en    (wr_en),
      .wr       (wr)
   );

endmodule

/* axi_mem_chk.sv */
`timescale 1ns/100ps

module axi_mem_chk (
   input logic                     clk,
   input logic                     rst,
   input axi_mem_pkg::axi_r_beat_t r,
   input logic                     rvalid,
   input logic                     rready,
   input logic                     arready,
   input logic                     awready,
   input logic                     wready,
   input logic                     bvalid,
   input logic                     bready
);

   // count of failed assertions
   int fail_cnt = 0;

   // ====================
   // handshake holds
   // ====================

   r_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(r))
      else begin
         $error("R beat dropped or changed while rready was low");
         fail_cnt++;
      end

   b_hold: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid)
      else begin
         $error("bvalid dropped while bready was low");
         fail_cnt++;
      end

   // ====================
   // one burst per engine
   // ====================

   ar_busy: assert property (@(posedge clk) disable iff (rst) rvalid |-> !arready)
      else begin
         $error("arready high during a read burst");
         fail_cnt++;
      end

   aw_busy: assert property (@(posedge clk) disable iff (rst) (wready || bvalid) |-> !awready)
      else begin
         $error("awready high during a write burst");
         fail_cnt++;
      end

   // slave channels idle straight out of reset
   reset_idle: assert property (@(posedge clk) rst |=> !rvalid && !wready && !bvalid)
      else begin
         $error("slave valid or ready high after reset");
         fail_cnt++;
      end

endmodule

bind axi_mem_top axi_mem_chk axi_mem_chk_i (
   .clk     (clk),
   .rst     (rst),
   .r       (r),
   .rvalid  (rvalid),
   .rready  (rready),
   .arready (arready),
   .awready (awready),
   .wready  (wready),
   .bvalid  (bvalid),
   .bready  (bready)
);

/* axi_mem_tb.sv */
`timescale 1ns/100ps
`include "axi_mem_consts.svh"

module axi_mem_tb;

   localparam int WAIT_LIMIT = 2000;

   logic clk, rst;
   axi_mem_pkg::axi_addr_req_t ar, aw;
   axi_mem_pkg::axi_w_beat_t   w;
   axi_mem_pkg::axi_r_beat_t   r;
   logic arvalid, arready, rvalid, rready;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic [1:0] bresp;

   integer      seed = 32'h549017ba;
   logic        bp_on;
   logic [31:0] shadow [`AXI_MEM_WORDS];

   // monitor view of the open bursts
   logic        rd_open = 1'b0;
   logic [31:0] rd_addr, wr_addr;
   logic [7:0]  rd_cnt, rd_len;
   int rd_expected = 0, rd_seen = 0, b_expected = 0, b_seen = 0;
   int mismatches = 0, other_errors = 0;

   axi_mem_top axi_mem_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ====================
   // reference model
   // ====================

   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
      end
      return res;
   endfunction

   function automatic logic [31:0] exp_read(input logic [31:0] addr);
      return shadow[axi_mem_pkg::word_index(addr)];
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
      mismatches++;
   endtask

   task automatic report_error(input string msg);
      $display("%s at %0t", msg, $time);
      other_errors++;
   endtask

   task automatic finish_run();
      int asserts;
      asserts = axi_mem_top_i.axi_mem_chk_i.fail_cnt;
      $display("errors: %0d mismatches, %0d other, %0d assertion failures",
               mismatches, other_errors, asserts);
      if (mismatches + other_errors + asserts == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   endtask

   // one cycle of a handshake wait
   task automatic tick_or_timeout(input string what, inout int cnt);
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
         report_error({"timeout waiting for ", what});
         finish_run();
      end
   endtask

   // ====================
   // bus drivers
   // ====================

   task automatic write_burst(input logic [31:0] addr, input logic [7:0] len,
                              input bit rand_data, input bit rand_strb);
      int          cnt;
      logic [31:0] beat_addr;
      logic [31:0] data;
      logic [3:0]  strb;
      @(posedge clk);
      aw      <= '{addr: addr, len: len, size: 3'd2, burst: 2'b01};
      awvalid <= 1'b1;
      cnt = 0;
      do tick_or_timeout("awready", cnt); while (!awready);
      @(posedge clk);
      awvalid <= 1'b0;
      beat_addr = addr;
      for (int k = 0; k <= int'(len); k++) begin
         data = rand_data ? 32'($random(seed)) : fill_word(beat_addr);
         strb = rand_strb ? 4'($random(seed)) : 4'hf;
         w      <= '{data: data, strb: strb, last: (k == int'(len))};
         wvalid <= 1'b1;
         cnt = 0;
         do tick_or_timeout("wready", cnt); while (!wready);
         @(posedge clk);
         beat_addr += 32'd4;
      end
      wvalid <= 1'b0;
      cnt = 0;
      do tick_or_timeout("B response", cnt); while (!(bvalid && bready));
      @(posedge clk);
   endtask

   task automatic read_burst(input logic [31:0] addr, input logic [7:0] len);
      int cnt;
      @(posedge clk);
      ar      <= '{addr: addr, len: len, size: 3'd2, burst: 2'b01};
      arvalid <= 1'b1;
      cnt = 0;
      do tick_or_timeout("arready", cnt); while (!arready);
      @(posedge clk);
      arvalid <= 1'b0;
      cnt = 0;
      do tick_or_timeout("last R beat", cnt); while (!(rvalid && rready && r.last));
      @(posedge clk);
   endtask

   // rready and bready back-pressure
   initial begin
      logic [31:0] bp_rnd;
      rready = 1'b1;
      bready = 1'b1;
      forever begin
         @(negedge clk);
         bp_rnd = $random(seed);
         @(posedge clk);
         rready <= !bp_on || bp_rnd[0];
         bready <= !bp_on || bp_rnd[1];
      end
   end

   // ====================
   // compare process
   // ====================

   always @(negedge clk) begin
      if (!rst) begin
         if (arvalid && arready) begin
            rd_open = 1'b1;
            rd_addr = ar.addr;
            rd_len  = ar.len;
            rd_cnt  = '0;
            rd_expected += int'(ar.len) + 1;
         end
         // read before write so a same-cycle hit sees the old word
         if (rvalid && rready) begin
            rd_seen++;
            if (!rd_open) begin
               report_error("R beat arrived with no read burst open");
            end else begin
               if (r.data !== exp_read(rd_addr)) begin
                  report_mismatch("r.data", r.data, exp_read(rd_addr));
               end
               if (r.last !== (rd_cnt == rd_len)) begin
                  report_mismatch("r.last", 32'(r.last), 32'(rd_cnt == rd_len));
               end
               if (r.resp !== `AXI_RESP_OKAY) begin
                  report_mismatch("r.resp", 32'(r.resp), 32'(`AXI_RESP_OKAY));
               end
               if (rd_cnt == rd_len) rd_open = 1'b0;
               rd_addr += 32'd4;
               rd_cnt  += 8'd1;
            end
         end
         if (awvalid && awready) begin
            wr_addr = aw.addr;
            b_expected++;
         end
         if (wvalid && wready) begin
            shadow[axi_mem_pkg::word_index(wr_addr)] =
               merge_bytes(exp_read(wr_addr), w.data, w.strb);
            wr_addr += 32'd4;
         end
         if (bvalid && bready) begin
            b_seen++;
            if (b_seen > b_expected) report_error("B response with no write burst open");
            if (bresp !== `AXI_RESP_OKAY) begin
               report_mismatch("bresp", 32'(bresp), 32'(`AXI_RESP_OKAY));
            end
         end
      end
   end

   // ====================
   // stimulus
   // ====================

   initial begin
      logic [31:0] rnd;
      logic [31:0] addr;
      logic [7:0]  len;
      logic [7:0]  len3;
      rst     = 1'b1;
      bp_on   = 1'b0;
      ar      = '0;
      aw      = '0;
      w       = '0;
      arvalid = 1'b0;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // idle ports after reset
      @(negedge clk);
      if (arready !== 1'b1) report_mismatch("arready", 32'(arready), 32'd1);
      if (awready !== 1'b1) report_mismatch("awready", 32'(awready), 32'd1);
      if (rvalid !== 1'b0) report_mismatch("rvalid", 32'(rvalid), 32'd0);
      if (wready !== 1'b0) report_mismatch("wready", 32'(wready), 32'd0);
      if (bvalid !== 1'b0) report_mismatch("bvalid", 32'(bvalid), 32'd0);

      // single beat write then read back
      write_burst(`AXI_MEM_BASE + 32'h40, 8'd0, 1'b1, 1'b0);
      read_burst(`AXI_MEM_BASE + 32'h40, 8'd0);
      if (b_seen != 1) report_error("single write did not give exactly one B response");

      // partial strobes over known fill data
      rnd  = $random(seed);
      len3 = {4'd0, rnd[3:0]};
      write_burst(`AXI_MEM_BASE + 32'h100, len3, 1'b0, 1'b0);
      write_burst(`AXI_MEM_BASE + 32'h100, len3, 1'b1, 1'b1);
      read_burst(`AXI_MEM_BASE + 32'h100, len3);

      // random back-pressure over several bursts
      bp_on <= 1'b1;
      repeat (6) begin
         rnd  = $random(seed);
         addr = `AXI_MEM_BASE + 32'h800 + {22'd0, rnd[7:0], 2'b00};
         len  = {4'd0, rnd[11:8]};
         write_burst(addr, len, 1'b1, 1'b0);
         write_burst(addr, len, 1'b1, 1'b1);
         read_burst(addr, len);
      end
      bp_on <= 1'b0;

      // concurrent write and read on disjoint ranges
      fork
         write_burst(`AXI_MEM_BASE + 32'h200, 8'd7, 1'b1, 1'b0);
         read_burst(`AXI_MEM_BASE + 32'h100, len3);
      join

      // high address aliases onto word 4
      if (int'(axi_mem_pkg::word_index(`AXI_MEM_BASE + 32'h1010)) != 4) begin
         report_error("high address does not alias onto the low word");
      end
      write_burst(`AXI_MEM_BASE + 32'h1010, 8'd0, 1'b1, 1'b0);
      read_burst(`AXI_MEM_BASE + 32'h10, 8'd0);

      repeat (4) @(posedge clk);
      if (rd_seen != rd_expected) begin
         report_error($sformatf("%0d R beats seen, %0d expected", rd_seen, rd_expected));
      end
      if (b_seen != b_expected) begin
         report_error($sformatf("%0d B responses seen, %0d expected", b_seen, b_expected));
      end
      finish_run();
   end

endmodule

/* list.f */
+incdir+.
axi_mem_pkg.sv
axi_word_store.sv
axi_read_engine.sv
axi_write_engine.sv
axi_mem_top.sv
axi_mem_chk.sv
axi_mem_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module axi_mem_tb > build.log 2>&1 &&
   ./obj_dir/Vaxi_mem_tb > sim.log 2>&1 &&
   grep -qx "TB PASSED" sim.log &&
   echo "simulation ok, see sim.log" ||
   { echo "simulation failed, see build.log and sim.log"; exit 1; }
